/* hdl/issue_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types of the single-issue stage
// register 0 reads as zero and is never pending
// fu class codes follow the functional-unit numbering of the core
// NUM_REGS must equal 2**REG_ADDR_WIDTH
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package issue_pkg;

	localparam int DATA_WIDTH     = 32;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int NUM_REGS       = 32;
	localparam int TICKET_WIDTH   = 3;
	localparam int FU_COUNT       = 4;
	localparam int CREDIT_WIDTH   = 3;

	// functional-unit classes
	typedef enum logic [1:0] {
		FU_LOAD_STORE = 2'b00,
		FU_FLOAT      = 2'b01,
		FU_INTEGER    = 2'b10,
		FU_BRANCH     = 2'b11
	} fu_class_e;

	// renamed instruction from upstream
	typedef struct packed {
		logic [REG_ADDR_WIDTH-1:0] source1;
		logic [REG_ADDR_WIDTH-1:0] source2;
		logic [REG_ADDR_WIDTH-1:0] destination;
		logic [TICKET_WIDTH-1:0]   ticket;
		fu_class_e                 fu;
		logic [4:0]                microop;
		logic                      source1_pc;
		logic                      source2_immediate;
		logic [DATA_WIDTH-1:0]     pc;
		logic [DATA_WIDTH-1:0]     immediate;
	} renamed_instr_t;

	// result bus from the functional units
	typedef struct packed {
		logic                      valid;
		logic [REG_ADDR_WIDTH-1:0] destination;
		logic [TICKET_WIDTH-1:0]   ticket;
		logic [DATA_WIDTH-1:0]     data;
	} writeback_t;

	// instruction and operands toward execution
	typedef struct packed {
		logic [REG_ADDR_WIDTH-1:0] destination;
		logic [TICKET_WIDTH-1:0]   ticket;
		fu_class_e                 fu;
		logic [4:0]                microop;
		logic [DATA_WIDTH-1:0]     pc;
		logic [DATA_WIDTH-1:0]     data1;
		logic [DATA_WIDTH-1:0]     data2;
	} dispatch_t;

	// one bit per fu class
	typedef logic [FU_COUNT-1:0] credit_vec_t;

endpackage

`default_nettype wire

/* hdl/register_file.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// physical register file, two reads and one write
// contents are not cleared by reset
// writes land at the clock edge and are held off in reset
// register 0 reads as zero, writes to it are dropped
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module register_file
	import issue_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      wr_en,
	input  logic [REG_ADDR_WIDTH-1:0] wr_addr,
	input  logic [DATA_WIDTH-1:0]     wr_data,
	input  logic [REG_ADDR_WIDTH-1:0] rd_addr1,
	input  logic [REG_ADDR_WIDTH-1:0] rd_addr2,
	output logic [DATA_WIDTH-1:0]     rd_data1,
	output logic [DATA_WIDTH-1:0]     rd_data2
);

	logic [DATA_WIDTH-1:0] regs [NUM_REGS];
	logic                  write_ok;

	// register 0 is hardwired, never stored
	assign write_ok = rst_n && wr_en && (wr_addr != '0);

	always_ff @(posedge clk) begin
		if (write_ok) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// asynchronous reads
	always_comb begin
		if (rd_addr1 == '0) begin
			rd_data1 = '0;
		end else begin
			rd_data1 = regs[rd_addr1];
		end
	end

	always_comb begin
		if (rd_addr2 == '0) begin
			rd_data2 = '0;
		end else begin
			rd_data2 = regs[rd_addr2];
		end
	end

endmodule

`default_nettype wire

/* hdl/scoreboard.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pending bit and newest-producer ticket per register
// an issue to a register wins over a writeback to it
// a writeback clears pending only on a ticket match
// register 0 is never pending
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module scoreboard
	import issue_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  writeback_t                wb,
	input  logic                      issue,
	input  logic [REG_ADDR_WIDTH-1:0] issue_dest,
	input  logic [TICKET_WIDTH-1:0]   issue_ticket,
	input  logic [REG_ADDR_WIDTH-1:0] lookup_src1,
	input  logic [REG_ADDR_WIDTH-1:0] lookup_src2,
	input  logic [REG_ADDR_WIDTH-1:0] lookup_dest,
	output logic                      pending_src1,
	output logic                      pending_src2,
	output logic                      pending_dest
);

	logic [NUM_REGS-1:0]     pending;
	logic [TICKET_WIDTH-1:0] tickets [NUM_REGS];
	logic                    issue_set;
	logic                    wb_clear;

	assign issue_set = issue && (issue_dest != '0);

	// older producers finishing late must not clear a newer claim
	assign wb_clear = wb.valid && (wb.ticket == tickets[wb.destination]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			pending[0] <= 1'b0;
			for (int i = 1; i < NUM_REGS; i++) begin
				if (issue_set && (issue_dest == REG_ADDR_WIDTH'(i))) begin
					pending[i] <= 1'b1;
				end else if (wb_clear && (wb.destination == REG_ADDR_WIDTH'(i))) begin
					pending[i] <= 1'b0;
				end
			end
		end
	end

	// newest producer of each register
	always_ff @(posedge clk) begin
		if (issue_set) begin
			tickets[issue_dest] <= issue_ticket;
		end
	end

	assign pending_src1 = pending[lookup_src1];
	assign pending_src2 = pending[lookup_src2];
	assign pending_dest = pending[lookup_dest];

endmodule

`default_nettype wire

/* hdl/operand_decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand selection for the incoming instruction
// priority: pc or immediate, then register file,
// then same-cycle writeback bypass for a pending source
// the bypass matches on destination only, not on ticket,
// so a writeback to a pending source always forwards
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module operand_decode
	import issue_pkg::*;
(
	input  renamed_instr_t        instr,
	input  writeback_t            wb,
	input  logic [DATA_WIDTH-1:0] rd_data1,
	input  logic [DATA_WIDTH-1:0] rd_data2,
	input  logic                  pending_src1,
	input  logic                  pending_src2,
	input  logic                  pending_dest,
	output logic [DATA_WIDTH-1:0] data1,
	output logic [DATA_WIDTH-1:0] data2,
	output logic                  operands_ready
);

	logic stall1;
	logic stall2;

	// returns {stall, operand} for one source
	function automatic logic [DATA_WIDTH:0] select_operand(
		input logic                      use_alt,
		input logic [DATA_WIDTH-1:0]     alt_data,
		input logic                      pending,
		input logic [REG_ADDR_WIDTH-1:0] source,
		input logic [DATA_WIDTH-1:0]     rf_data,
		input writeback_t                bus
	);
		logic [DATA_WIDTH:0] result;
		if (use_alt) begin
			result = {1'b0, alt_data};
		end else if (!pending) begin
			result = {1'b0, rf_data};
		end else if (bus.valid && (bus.destination == source)) begin
			// producer finishing this cycle
			result = {1'b0, bus.data};
		end else begin
			// value not produced yet
			result = {1'b1, rf_data};
		end
		return result;
	endfunction

	assign {stall1, data1} = select_operand(
		instr.source1_pc,
		instr.pc,
		pending_src1,
		instr.source1,
		rd_data1,
		wb
	);

	assign {stall2, data2} = select_operand(
		instr.source2_immediate,
		instr.immediate,
		pending_src2,
		instr.source2,
		rd_data2,
		wb
	);

	// WAW on the destination also holds the instruction
	assign operands_ready = !stall1 && !stall2 && !pending_dest;

endmodule

`default_nettype wire

/* hdl/issue_control.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue decision and per-class credit counters
// issue is combinational in the current inputs
// a return and an issue in the same cycle cancel
// counts saturate at CREDITS, valid range 1 to 7
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module issue_control
	import issue_pkg::*;
#(
	parameter int CREDITS = 2
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        instr_valid,
	input  fu_class_e   fu,
	input  logic        operands_ready,
	input  credit_vec_t credit_return,
	output logic        issue
);

	localparam logic [CREDIT_WIDTH-1:0] CREDIT_MAX = CREDIT_WIDTH'(CREDITS);

	logic [CREDIT_WIDTH-1:0] credit_count [FU_COUNT];
	credit_vec_t             has_credit;
	credit_vec_t             consume;

	// per-class grant view
	always_comb begin
		for (int i = 0; i < FU_COUNT; i++) begin
			has_credit[i] = (credit_count[i] != '0);
		end
	end

	assign issue = instr_valid && operands_ready && has_credit[fu];

	// one-hot of the class taking a credit
	always_comb begin
		consume = '0;
		if (issue) begin
			consume[fu] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < FU_COUNT; i++) begin
				credit_count[i] <= CREDIT_MAX;
			end
		end else begin
			for (int i = 0; i < FU_COUNT; i++) begin
				if (consume[i] && !credit_return[i]) begin
					credit_count[i] <= credit_count[i] - 1'b1;
				end else if (credit_return[i] && !consume[i]) begin
					// extra returns beyond the pool are dropped
					if (credit_count[i] < CREDIT_MAX) begin
						credit_count[i] <= credit_count[i] + 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/dispatch_register.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dispatch register toward the functional units
// disp_valid pulses for one cycle after each issue
// disp holds its last value while disp_valid is low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module dispatch_register
	import issue_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue,
	input  renamed_instr_t        instr,
	input  logic [DATA_WIDTH-1:0] data1,
	input  logic [DATA_WIDTH-1:0] data2,
	output logic                  disp_valid,
	output dispatch_t             disp
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			disp_valid <= 1'b0;
		end else begin
			disp_valid <= issue;
		end
	end

	// payload captured at the issue edge
	always_ff @(posedge clk) begin
		if (issue) begin
			disp.destination <= instr.destination;
			disp.ticket      <= instr.ticket;
			disp.fu          <= instr.fu;
			disp.microop     <= instr.microop;
			disp.pc          <= instr.pc;
			disp.data1       <= data1;
			disp.data2       <= data2;
		end
	end

endmodule

`default_nettype wire

/* hdl/issue_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-issue stage of the out-of-order core
// instr is held with instr_valid high until issue
// back-pressure comes only from the fu credits
// up to CREDITS dispatches per class can be in flight
// register file contents are undefined after reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module issue_stage
	import issue_pkg::*;
#(
	parameter int CREDITS = 2
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           instr_valid,
	input  renamed_instr_t instr,
	output logic           issue,
	input  writeback_t     wb,
	input  credit_vec_t    credit_return,
	output logic           disp_valid,
	output dispatch_t      disp
);

	logic [DATA_WIDTH-1:0] rd_data1;
	logic [DATA_WIDTH-1:0] rd_data2;
	logic [DATA_WIDTH-1:0] data1;
	logic [DATA_WIDTH-1:0] data2;
	logic                  pending_src1;
	logic                  pending_src2;
	logic                  pending_dest;
	logic                  operands_ready;

	// results are committed straight from the writeback bus
	register_file u_register_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wb.valid),
		.wr_addr  (wb.destination),
		.wr_data  (wb.data),
		.rd_addr1 (instr.source1),
		.rd_addr2 (instr.source2),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2)
	);

	scoreboard u_scoreboard (
		.clk          (clk),
		.rst_n        (rst_n),
		.wb           (wb),
		.issue        (issue),
		.issue_dest   (instr.destination),
		.issue_ticket (instr.ticket),
		.lookup_src1  (instr.source1),
		.lookup_src2  (instr.source2),
		.lookup_dest  (instr.destination),
		.pending_src1 (pending_src1),
		.pending_src2 (pending_src2),
		.pending_dest (pending_dest)
	);

	operand_decode u_operand_decode (
		.instr          (instr),
		.wb             (wb),
		.rd_data1       (rd_data1),
		.rd_data2       (rd_data2),
		.pending_src1   (pending_src1),
		.pending_src2   (pending_src2),
		.pending_dest   (pending_dest),
		.data1          (data1),
		.data2          (data2),
		.operands_ready (operands_ready)
	);

	issue_control #(
		.CREDITS (CREDITS)
	) u_issue_control (
		.clk            (clk),
		.rst_n          (rst_n),
		.instr_valid    (instr_valid),
		.fu             (instr.fu),
		.operands_ready (operands_ready),
		.credit_return  (credit_return),
		.issue          (issue)
	);

	dispatch_register u_dispatch_register (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.instr      (instr),
		.data1      (data1),
		.data2      (data2),
		.disp_valid (disp_valid),
		.disp       (disp)
	);

endmodule

`default_nettype wire

/* sim/issue_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests for issue_stage with CREDITS at 2
// inputs change on the rising edge and outputs are read
// on the falling edge
// register contents are written through wb before use
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module issue_tb
	import issue_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	logic           clk;
	logic           rst_n;
	logic           instr_valid;
	renamed_instr_t instr;
	logic           issue;
	writeback_t     wb;
	credit_vec_t    credit_return;
	logic           disp_valid;
	dispatch_t      disp;

	logic [31:0] lfsr_state;
	int          errors;
	int          checks;
	int          tests;
	int          test_errors;

	issue_stage #(
		.CREDITS (2)
	) uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.issue         (issue),
		.wb            (wb),
		.credit_return (credit_return),
		.disp_valid    (disp_valid),
		.disp          (disp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois form of x^32 + x^31 + x^29 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 32'hd000_0001;
		end
		return next;
	endfunction

	// one lfsr step per bit
	task automatic random_word(output logic [31:0] value);
		value = '0;
		for (int b = 0; b < 32; b++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic renamed_instr_t make_instr(
		input logic [4:0] src1,
		input logic [4:0] src2,
		input logic [4:0] dest,
		input logic [2:0] ticket,
		input fu_class_e  fu,
		input logic [4:0] microop
	);
		renamed_instr_t i;
		i = '0;
		i.source1     = src1;
		i.source2     = src2;
		i.destination = dest;
		i.ticket      = ticket;
		i.fu          = fu;
		i.microop     = microop;
		i.pc          = 32'h0000_4000 | {25'd0, microop, 2'b00};
		i.immediate   = 32'hffff_ff00 | {27'd0, microop};
		return i;
	endfunction

	function automatic credit_vec_t credit_bit(input fu_class_e fu);
		credit_vec_t bits;
		bits = '0;
		bits[fu] = 1'b1;
		return bits;
	endfunction

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		test_errors++;
	endtask

	task automatic present(input renamed_instr_t i);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= i;
	endtask

	task automatic drive_wb(input logic [4:0] dest, input logic [2:0] ticket,
		input logic [31:0] data);
		writeback_t w;
		w.valid       = 1'b1;
		w.destination = dest;
		w.ticket      = ticket;
		w.data        = data;
		@(posedge clk);
		wb <= w;
	endtask

	// instruction stays presented
	task automatic clear_bus();
		@(posedge clk);
		wb            <= '0;
		credit_return <= '0;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		instr_valid   <= 1'b0;
		wb            <= '0;
		credit_return <= '0;
	endtask

	task automatic write_reg(input logic [4:0] dest, input logic [2:0] ticket,
		input logic [31:0] data);
		drive_wb(dest, ticket, data);
		clear_bus();
	endtask

	task automatic return_credit(input fu_class_e fu);
		@(posedge clk);
		credit_return <= credit_bit(fu);
		clear_bus();
	endtask

	// unit finishes with its result on wb and its credit back
	task automatic retire(input fu_class_e fu, input logic [4:0] dest, input logic [2:0] ticket);
		logic [31:0] d;
		random_word(d);
		drive_wb(dest, ticket, d);
		credit_return <= credit_bit(fu);
		clear_bus();
	endtask

	task automatic expect_issue_now();
		@(negedge clk);
		check_hex("issue", 32'(issue), 32'h1);
	endtask

	task automatic expect_stall(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_hex("issue", 32'(issue), 32'h0);
		end
	endtask

	task automatic wait_for_issue(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (issue !== 1'b1 && n < limit) begin
			@(negedge clk);
			n++;
		end
		checks++;
		if (issue !== 1'b1) begin
			report_failure($sformatf("timeout, issue did not rise within %0d cycles", limit));
		end
	endtask

	// called at the falling edge where issue is high
	task automatic expect_dispatch(input renamed_instr_t i, input logic [31:0] exp1,
		input logic [31:0] exp2);
		idle_cycle();
		@(negedge clk);
		check_hex("disp_valid", 32'(disp_valid), 32'h1);
		check_hex("disp.destination", 32'(disp.destination), 32'(i.destination));
		check_hex("disp.ticket", 32'(disp.ticket), 32'(i.ticket));
		check_hex("disp.fu", 32'(disp.fu), 32'(i.fu));
		check_hex("disp.microop", 32'(disp.microop), 32'(i.microop));
		check_hex("disp.pc", disp.pc, i.pc);
		check_hex("disp.data1", disp.data1, exp1);
		check_hex("disp.data2", disp.data2, exp2);
		// single-cycle pulse
		@(negedge clk);
		check_hex("disp_valid", 32'(disp_valid), 32'h0);
	endtask

	task automatic finish_test(input string name);
		tests++;
		errors += test_errors;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d error(s)", name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic test_register_read();
		logic [31:0]    d1;
		logic [31:0]    d2;
		renamed_instr_t i;
		random_word(d1);
		random_word(d2);
		write_reg(5'd3, 3'd0, d1);
		write_reg(5'd4, 3'd0, d2);
		i = make_instr(5'd3, 5'd4, 5'd10, 3'd5, FU_INTEGER, 5'h0b);
		present(i);
		expect_issue_now();
		expect_dispatch(i, d1, d2);
		retire(FU_INTEGER, 5'd10, 3'd5);
		finish_test("register read");
	endtask

	task automatic test_operand_select();
		logic [31:0]    z;
		renamed_instr_t i;
		random_word(z);
		write_reg(5'd0, 3'd0, z);
		i = make_instr(5'd0, 5'd0, 5'd0, 3'd1, FU_BRANCH, 5'h12);
		i.source1_pc        = 1'b1;
		i.source2_immediate = 1'b1;
		random_word(i.pc);
		random_word(i.immediate);
		present(i);
		expect_issue_now();
		expect_dispatch(i, i.pc, i.immediate);
		return_credit(FU_BRANCH);
		// writer and then reader of register 0
		i = make_instr(5'd0, 5'd0, 5'd0, 3'd2, FU_LOAD_STORE, 5'h03);
		present(i);
		expect_issue_now();
		expect_dispatch(i, 32'h0, 32'h0);
		return_credit(FU_LOAD_STORE);
		i = make_instr(5'd0, 5'd0, 5'd0, 3'd3, FU_LOAD_STORE, 5'h07);
		present(i);
		expect_issue_now();
		expect_dispatch(i, 32'h0, 32'h0);
		return_credit(FU_LOAD_STORE);
		finish_test("operand select and register 0");
	endtask

	task automatic test_raw_bypass();
		logic [31:0]    d;
		renamed_instr_t producer;
		renamed_instr_t consumer;
		producer = make_instr(5'd0, 5'd0, 5'd5, 3'd1, FU_INTEGER, 5'h01);
		present(producer);
		expect_issue_now();
		expect_dispatch(producer, 32'h0, 32'h0);
		return_credit(FU_INTEGER);
		consumer = make_instr(5'd5, 5'd0, 5'd12, 3'd2, FU_INTEGER, 5'h02);
		present(consumer);
		expect_stall(3);
		random_word(d);
		drive_wb(5'd5, 3'd1, d);
		expect_issue_now();
		expect_dispatch(consumer, d, 32'h0);
		retire(FU_INTEGER, 5'd12, 3'd2);
		finish_test("read-after-write stall and bypass");
	endtask

	task automatic test_stale_ticket();
		logic [31:0]    junk;
		logic [31:0]    d;
		renamed_instr_t first;
		renamed_instr_t second;
		renamed_instr_t reader;
		first = make_instr(5'd0, 5'd0, 5'd7, 3'd2, FU_INTEGER, 5'h04);
		present(first);
		expect_issue_now();
		expect_dispatch(first, 32'h0, 32'h0);
		return_credit(FU_INTEGER);
		// second producer waits on the pending destination
		second = make_instr(5'd0, 5'd0, 5'd7, 3'd3, FU_INTEGER, 5'h05);
		present(second);
		expect_stall(2);
		random_word(junk);
		drive_wb(5'd7, 3'd2, junk);
		clear_bus();
		wait_for_issue(8);
		expect_dispatch(second, 32'h0, 32'h0);
		return_credit(FU_INTEGER);
		// late result carrying the old ticket
		random_word(junk);
		write_reg(5'd7, 3'd2, junk);
		reader = make_instr(5'd7, 5'd0, 5'd13, 3'd4, FU_INTEGER, 5'h06);
		present(reader);
		expect_stall(3);
		random_word(d);
		drive_wb(5'd7, 3'd3, d);
		expect_issue_now();
		expect_dispatch(reader, d, 32'h0);
		retire(FU_INTEGER, 5'd13, 3'd4);
		finish_test("stale ticket");
	endtask

	task automatic test_credits();
		renamed_instr_t first;
		renamed_instr_t second;
		renamed_instr_t third;
		renamed_instr_t mem;
		first  = make_instr(5'd0, 5'd0, 5'd0, 3'd1, FU_INTEGER, 5'h08);
		second = make_instr(5'd0, 5'd0, 5'd0, 3'd2, FU_INTEGER, 5'h09);
		third  = make_instr(5'd0, 5'd0, 5'd0, 3'd3, FU_INTEGER, 5'h0a);
		mem    = make_instr(5'd0, 5'd0, 5'd0, 3'd4, FU_LOAD_STORE, 5'h0c);
		present(first);
		expect_issue_now();
		expect_dispatch(first, 32'h0, 32'h0);
		present(second);
		expect_issue_now();
		expect_dispatch(second, 32'h0, 32'h0);
		// integer pool is empty now
		present(third);
		expect_stall(3);
		present(mem);
		expect_issue_now();
		expect_dispatch(mem, 32'h0, 32'h0);
		return_credit(FU_LOAD_STORE);
		present(third);
		expect_stall(2);
		return_credit(FU_INTEGER);
		wait_for_issue(8);
		expect_dispatch(third, 32'h0, 32'h0);
		finish_test("credits");
	endtask

	initial begin
		rst_n         = 1'b0;
		instr_valid   = 1'b0;
		instr         = '0;
		wb            = '0;
		credit_return = '0;
		lfsr_state    = 32'h9c83_249a;
		errors        = 0;
		checks        = 0;
		tests         = 0;
		test_errors   = 0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_hex("issue", 32'(issue), 32'h0);
		check_hex("disp_valid", 32'(disp_valid), 32'h0);
		finish_test("reset");
		test_register_read();
		test_operand_select();
		test_raw_bypass();
		test_stale_ticket();
		test_credits();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
hdl/issue_pkg.sv
hdl/register_file.sv
hdl/scoreboard.sv
hdl/operand_decode.sv
hdl/issue_control.sv
hdl/dispatch_register.sv
hdl/issue_stage.sv
sim/issue_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the issue stage testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module issue_tb \
	-f compile.f \
	-Mdir obj_dir

./obj_dir/Vissue_tb | tee sim.log

if ! grep -q "^Verification passed$" sim.log; then
	echo "simulation reported errors, see sim.log"
	exit 1
fi

echo "simulation clean"
